// ==== ex_pkg.sv ====
package ex_pkg;

   // datapath widths
   localparam int reg_w      = 32;
   localparam int reg_addr_w = 5;

   // one stall bit per stage for pc, if, id, ex, mem and wb
   localparam int stall_w   = 6;
   localparam int stall_id  = 2;
   localparam int stall_ex  = 3;
   localparam int stall_mem = 4;

   // operation codes in the numbering the decoder uses
   typedef enum logic [7:0] {
      op_nop  = 8'b0000_0000,
      op_and  = 8'b0010_0100,
      op_or   = 8'b0010_0101,
      op_xor  = 8'b0010_0110,
      op_nor  = 8'b0010_0111,
      op_lui  = 8'b0101_1100,
      op_sll  = 8'b0111_1100,
      op_srl  = 8'b0000_0010,
      op_sra  = 8'b0000_0011,
      op_add  = 8'b0010_0000,
      op_addu = 8'b0010_0001,
      op_sub  = 8'b0010_0010,
      op_subu = 8'b0010_0011,
      op_slt  = 8'b0010_1010,
      op_sltu = 8'b0010_1011,
      op_jal  = 8'b0101_0000
   } aluop_e;

   // result class that picks which unit output is written back
   typedef enum logic [2:0] {
      res_nop   = 3'b000,
      res_logic = 3'b001,
      res_shift = 3'b010,
      res_arith = 3'b100,
      res_jump  = 3'b110
   } alusel_e;

   // reset and bubble values
   localparam logic [reg_w-1:0]      zero_word    = '0;
   localparam logic [reg_addr_w-1:0] nop_reg_addr = '0;

endpackage

// ==== id_ex.sv ====
`timescale 1ns/1ps

module id_ex
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [ex_pkg::stall_w-1:0]     stall,

   // decoded operands from the id stage
   input  ex_pkg::aluop_e                 id_aluop,
   input  ex_pkg::alusel_e                id_alusel,
   input  logic [ex_pkg::reg_w-1:0]       id_reg1,
   input  logic [ex_pkg::reg_w-1:0]       id_reg2,
   input  logic [ex_pkg::reg_w-1:0]       id_link_address,
   input  logic [ex_pkg::reg_w-1:0]       id_inst,
   input  logic [ex_pkg::reg_addr_w-1:0]  id_wd,
   input  logic                           id_wreg,

   // registered copy for the ex stage
   output ex_pkg::aluop_e                 ex_aluop,
   output ex_pkg::alusel_e                ex_alusel,
   output logic [ex_pkg::reg_w-1:0]       ex_reg1,
   output logic [ex_pkg::reg_w-1:0]       ex_reg2,
   output logic [ex_pkg::reg_w-1:0]       ex_link_address,
   output logic [ex_pkg::reg_w-1:0]       ex_inst,
   output logic [ex_pkg::reg_addr_w-1:0]  ex_wd,
   output logic                           ex_wreg
);

   import ex_pkg::*;

   logic load_bubble;
   logic load_new;

   // push a nop into ex while id is stalled and ex runs on
   assign load_bubble = stall[stall_id] & ~stall[stall_ex];
   assign load_new    = ~stall[stall_id];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ex_aluop        <= op_nop;
         ex_alusel       <= res_nop;
         ex_reg1         <= zero_word;
         ex_reg2         <= zero_word;
         ex_link_address <= zero_word;
         ex_inst         <= zero_word;
         ex_wd           <= nop_reg_addr;
         ex_wreg         <= 1'b0;
      end
      else if (load_bubble)
      begin
         ex_aluop        <= op_nop;
         ex_alusel       <= res_nop;
         ex_reg1         <= zero_word;
         ex_reg2         <= zero_word;
         ex_link_address <= zero_word;
         ex_inst         <= zero_word;
         ex_wd           <= nop_reg_addr;
         ex_wreg         <= 1'b0;
      end
      else if (load_new)
      begin
         ex_aluop        <= id_aluop;
         ex_alusel       <= id_alusel;
         ex_reg1         <= id_reg1;
         ex_reg2         <= id_reg2;
         ex_link_address <= id_link_address;
         ex_inst         <= id_inst;
         ex_wd           <= id_wd;
         ex_wreg         <= id_wreg;
      end
      // hold while both id and ex are stalled
   end

endmodule

// ==== alu_logic.sv ====
`timescale 1ns/1ps

module alu_logic
(
   input  ex_pkg::aluop_e            ex_aluop,
   input  logic [ex_pkg::reg_w-1:0]  ex_reg1,
   input  logic [ex_pkg::reg_w-1:0]  ex_reg2,
   output logic [ex_pkg::reg_w-1:0]  logic_res,
   output logic [ex_pkg::reg_w-1:0]  shift_res
);

   import ex_pkg::*;

   logic [4:0] shamt;

   // shift amount comes from the low bits of reg1
   assign shamt = ex_reg1[4:0];

   // bitwise operations and lui
   always_comb
   begin
      case (ex_aluop)
         op_and:  logic_res = ex_reg1 & ex_reg2;
         op_or:   logic_res = ex_reg1 | ex_reg2;
         op_xor:  logic_res = ex_reg1 ^ ex_reg2;
         op_nor:  logic_res = ~(ex_reg1 | ex_reg2);
         // immediate sits in the low half of reg2
         op_lui:  logic_res = {ex_reg2[15:0], 16'h0000};
         default: logic_res = zero_word;
      endcase
   end

   // shifts operate on reg2
   always_comb
   begin
      case (ex_aluop)
         op_sll:
         begin
            shift_res = ex_reg2 << shamt;
         end
         op_srl:
         begin
            shift_res = ex_reg2 >> shamt;
         end
         op_sra:
         begin
            shift_res = $unsigned($signed(ex_reg2) >>> shamt);
         end
         default:
         begin
            shift_res = zero_word;
         end
      endcase
   end

endmodule

// ==== alu_arith.sv ====
`timescale 1ns/1ps

module alu_arith
(
   input  ex_pkg::aluop_e            ex_aluop,
   input  logic [ex_pkg::reg_w-1:0]  ex_reg1,
   input  logic [ex_pkg::reg_w-1:0]  ex_reg2,
   input  logic [ex_pkg::reg_w-1:0]  ex_link_address,
   output logic [ex_pkg::reg_w-1:0]  arith_res,
   output logic [ex_pkg::reg_w-1:0]  link_res,
   output logic                      ovf
);

   import ex_pkg::*;

   logic             is_sub;
   logic [reg_w-1:0] operand_b;
   logic [reg_w-1:0] sum;
   logic             sum_ovf;
   logic             lt_signed;
   logic             lt_unsigned;

   // subtract by adding the two's complement of reg2
   assign is_sub    = (ex_aluop == op_sub) || (ex_aluop == op_subu);
   assign operand_b = is_sub ? (~ex_reg2 + 1'b1) : ex_reg2;
   assign sum       = ex_reg1 + operand_b;

   // effective operand signs agree and the sum sign differs
   assign sum_ovf = (ex_reg1[reg_w-1] == (ex_reg2[reg_w-1] ^ is_sub)) &&
                    (sum[reg_w-1] != ex_reg1[reg_w-1]);

   assign lt_signed   = $signed(ex_reg1) < $signed(ex_reg2);
   assign lt_unsigned = ex_reg1 < ex_reg2;

   // only the trapping forms flag overflow
   assign ovf = sum_ovf && ((ex_aluop == op_add) || (ex_aluop == op_sub));

   always_comb
   begin
      case (ex_aluop)
         op_add, op_addu, op_sub, op_subu:
         begin
            arith_res = sum;
         end
         op_slt:
         begin
            arith_res = {{(reg_w-1){1'b0}}, lt_signed};
         end
         op_sltu:
         begin
            arith_res = {{(reg_w-1){1'b0}}, lt_unsigned};
         end
         default:
         begin
            arith_res = zero_word;
         end
      endcase
   end

   // return address for jal
   assign link_res = (ex_aluop == op_jal) ? ex_link_address : zero_word;

endmodule

// ==== ex_result_sel.sv ====
`timescale 1ns/1ps

module ex_result_sel
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [ex_pkg::stall_w-1:0]     stall,
   input  ex_pkg::alusel_e                ex_alusel,
   input  logic [ex_pkg::reg_addr_w-1:0]  ex_wd,
   input  logic                           ex_wreg,
   input  logic [ex_pkg::reg_w-1:0]       logic_res,
   input  logic [ex_pkg::reg_w-1:0]       shift_res,
   input  logic [ex_pkg::reg_w-1:0]       arith_res,
   input  logic [ex_pkg::reg_w-1:0]       link_res,
   input  logic                           ovf,
   output logic [ex_pkg::reg_addr_w-1:0]  wb_wd,
   output logic [ex_pkg::reg_w-1:0]       wb_wdata,
   output logic                           wb_wreg
);

   import ex_pkg::*;

   logic [reg_w-1:0] wdata_sel;
   logic             wreg_sel;

   always_comb
   begin
      case (ex_alusel)
         res_logic: wdata_sel = logic_res;
         res_shift: wdata_sel = shift_res;
         res_arith: wdata_sel = arith_res;
         res_jump:  wdata_sel = link_res;
         default:   wdata_sel = zero_word;
      endcase
   end

   // signed overflow cancels the register write
   assign wreg_sel = ex_wreg & ~ovf;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_wd    <= nop_reg_addr;
         wb_wdata <= zero_word;
         wb_wreg  <= 1'b0;
      end
      else if (stall[stall_ex] && !stall[stall_mem])
      begin
         wb_wd    <= nop_reg_addr;
         wb_wdata <= zero_word;
         wb_wreg  <= 1'b0;
      end
      else if (!stall[stall_ex])
      begin
         wb_wd    <= ex_wd;
         wb_wdata <= wdata_sel;
         wb_wreg  <= wreg_sel;
      end
   end

endmodule

// ==== ex_top.sv ====
`timescale 1ns/1ps

module ex_top
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [ex_pkg::stall_w-1:0]     stall,
   input  ex_pkg::aluop_e                 id_aluop,
   input  ex_pkg::alusel_e                id_alusel,
   input  logic [ex_pkg::reg_w-1:0]       id_reg1,
   input  logic [ex_pkg::reg_w-1:0]       id_reg2,
   input  logic [ex_pkg::reg_w-1:0]       id_link_address,
   input  logic [ex_pkg::reg_w-1:0]       id_inst,
   input  logic [ex_pkg::reg_addr_w-1:0]  id_wd,
   input  logic                           id_wreg,
   output logic [ex_pkg::reg_addr_w-1:0]  wb_wd,
   output logic [ex_pkg::reg_w-1:0]       wb_wdata,
   output logic                           wb_wreg,
   output logic [ex_pkg::reg_w-1:0]       dbg_inst
);

   import ex_pkg::*;

   // id_ex outputs
   aluop_e                ex_aluop;
   alusel_e               ex_alusel;
   logic [reg_w-1:0]      ex_reg1;
   logic [reg_w-1:0]      ex_reg2;
   logic [reg_w-1:0]      ex_link_address;
   logic [reg_addr_w-1:0] ex_wd;
   logic                  ex_wreg;

   // unit results
   logic [reg_w-1:0]      logic_res;
   logic [reg_w-1:0]      shift_res;
   logic [reg_w-1:0]      arith_res;
   logic [reg_w-1:0]      link_res;
   logic                  ovf;

   id_ex i_id_ex (
      .clk(clk), .arst_n(arst_n), .stall(stall),
      .id_aluop(id_aluop), .id_alusel(id_alusel), .id_reg1(id_reg1), .id_reg2(id_reg2),
      .id_link_address(id_link_address), .id_inst(id_inst), .id_wd(id_wd),
      .id_wreg(id_wreg), .ex_aluop(ex_aluop), .ex_alusel(ex_alusel), .ex_reg1(ex_reg1),
      .ex_reg2(ex_reg2), .ex_link_address(ex_link_address), .ex_inst(dbg_inst),
      .ex_wd(ex_wd), .ex_wreg(ex_wreg)
   );

   alu_logic i_alu_logic (
      .ex_aluop(ex_aluop), .ex_reg1(ex_reg1), .ex_reg2(ex_reg2),
      .logic_res(logic_res), .shift_res(shift_res)
   );

   alu_arith i_alu_arith (
      .ex_aluop(ex_aluop), .ex_reg1(ex_reg1), .ex_reg2(ex_reg2),
      .ex_link_address(ex_link_address), .arith_res(arith_res),
      .link_res(link_res), .ovf(ovf)
   );

   ex_result_sel i_ex_result_sel (
      .clk(clk), .arst_n(arst_n), .stall(stall), .ex_alusel(ex_alusel),
      .ex_wd(ex_wd), .ex_wreg(ex_wreg), .logic_res(logic_res), .shift_res(shift_res),
      .arith_res(arith_res), .link_res(link_res), .ovf(ovf),
      .wb_wd(wb_wd), .wb_wdata(wb_wdata), .wb_wreg(wb_wreg)
   );

endmodule

// ==== tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top;

   import ex_pkg::*;

   logic                  clk;
   logic                  arst_n;
   logic [stall_w-1:0]    stall;
   aluop_e                id_aluop;
   alusel_e               id_alusel;
   logic [reg_w-1:0]      id_reg1;
   logic [reg_w-1:0]      id_reg2;
   logic [reg_w-1:0]      id_link_address;
   logic [reg_w-1:0]      id_inst;
   logic [reg_addr_w-1:0] id_wd;
   logic                  id_wreg;
   logic [reg_addr_w-1:0] wb_wd;
   logic [reg_w-1:0]      wb_wdata;
   logic                  wb_wreg;
   logic [reg_w-1:0]      dbg_inst;

   // one entry per line of the case file
   logic [31:0] cs_stall [0:63];
   logic [31:0] cs_aluop [0:63];
   logic [31:0] cs_alusel [0:63];
   logic [31:0] cs_reg1 [0:63];
   logic [31:0] cs_reg2 [0:63];
   logic [31:0] cs_wd [0:63];
   logic [31:0] cs_wreg [0:63];
   logic [31:0] cs_link [0:63];
   logic [31:0] cs_exp_wd [0:63];
   logic [31:0] cs_exp_wreg [0:63];
   logic [31:0] cs_exp_wdata [0:63];
   logic [31:0] cs_inst [0:63];

   int          n_cases = 0;
   bit          cases_loaded = 1'b0;

   ex_top i_dut (
      .clk(clk), .arst_n(arst_n), .stall(stall),
      .id_aluop(id_aluop), .id_alusel(id_alusel), .id_reg1(id_reg1), .id_reg2(id_reg2),
      .id_link_address(id_link_address), .id_inst(id_inst), .id_wd(id_wd),
      .id_wreg(id_wreg), .wb_wd(wb_wd), .wb_wdata(wb_wdata), .wb_wreg(wb_wreg),
      .dbg_inst(dbg_inst)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #4 clk = ~clk;

   task automatic abort_run(input string why);
   begin
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run aborted");
   end
   endtask

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
   begin
      if (actual !== expected)
      begin
         $display("[ERROR] time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
         $display("Test failed");
         $fatal(1, "mismatch on %s", name);
      end
   end
   endtask

   task automatic check_wb(input logic [31:0] exp_wd, input logic [31:0] exp_wreg,
                           input logic [31:0] exp_wdata);
   begin
      check_val("wb_wd", 32'(wb_wd), exp_wd);
      check_val("wb_wreg", 32'(wb_wreg), exp_wreg);
      check_val("wb_wdata", wb_wdata, exp_wdata);
   end
   endtask

   task automatic load_cases;
      int          fd;
      int          got;
      string       line_str;
      logic [31:0] f [0:10];
   begin
      fd = $fopen("ex_cases.txt", "r");
      if (fd == 0)
         abort_run("could not open ex_cases.txt");
      while (!$feof(fd))
      begin
         line_str = "";
         got = $fgets(line_str, fd);
         // skip comments and blank lines
         if (got > 0 && line_str.len() > 1 && line_str[0] != "#")
         begin
            got = $sscanf(line_str, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                          f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (got != 11)
               abort_run("a line of ex_cases.txt does not have eleven fields");
            if (n_cases >= 64)
               abort_run("ex_cases.txt holds more cases than the testbench can store");
            cs_stall[n_cases]     = f[0];
            cs_aluop[n_cases]     = f[1];
            cs_alusel[n_cases]    = f[2];
            cs_reg1[n_cases]      = f[3];
            cs_reg2[n_cases]      = f[4];
            cs_wd[n_cases]        = f[5];
            cs_wreg[n_cases]      = f[6];
            cs_link[n_cases]      = f[7];
            cs_exp_wd[n_cases]    = f[8];
            cs_exp_wreg[n_cases]  = f[9];
            cs_exp_wdata[n_cases] = f[10];
            n_cases++;
         end
      end
      $fclose(fd);
      if (n_cases == 0)
         abort_run("ex_cases.txt holds no cases");
      cases_loaded = 1'b1;
   end
   endtask

   task automatic drive_idle;
   begin
      stall           = '0;
      id_aluop        = op_nop;
      id_alusel       = res_nop;
      id_reg1         = '0;
      id_reg2         = '0;
      id_link_address = '0;
      id_inst         = '0;
      id_wd           = '0;
      id_wreg         = 1'b0;
   end
   endtask

   // an active item that must not reach the outputs while reset is low
   task automatic drive_reset_noise;
   begin
      id_aluop  = op_or;
      id_alusel = res_logic;
      id_reg1   = 32'hffff_ffff;
      id_reg2   = 32'h0000_1234;
      id_inst   = $urandom();
      id_wd     = 5'd5;
      id_wreg   = 1'b1;
   end
   endtask

   task automatic drive_case(input int idx);
   begin
      stall           = cs_stall[idx][stall_w-1:0];
      id_aluop        = aluop_e'(cs_aluop[idx][7:0]);
      id_alusel       = alusel_e'(cs_alusel[idx][2:0]);
      id_reg1         = cs_reg1[idx];
      id_reg2         = cs_reg2[idx];
      id_link_address = cs_link[idx];
      id_inst         = cs_inst[idx];
      id_wd           = cs_wd[idx][reg_addr_w-1:0];
      id_wreg         = cs_wreg[idx][0];
   end
   endtask

   // limit covers reset, every case and some spare cycles
   initial
   begin
      wait (cases_loaded);
      #((n_cases + 5 + 10) * 8);
      abort_run("watchdog expired before all cases were applied");
   end

   initial
   begin
      int                 seed_dummy;
      logic [stall_w-1:0] prev_stall;
      logic [reg_w-1:0]   prev_inst;
      logic [reg_w-1:0]   exp_inst;
      drive_idle();
      arst_n = 1'b0;
      seed_dummy = $urandom(32'h7cad5991);
      load_cases();
      for (int k = 0; k < n_cases; k++)
         cs_inst[k] = $urandom();

      // outputs stay cleared for the whole reset
      for (int c = 1; c <= 5; c++)
      begin
         @(posedge clk);
         #1;
         check_wb(32'h0, 32'h0, 32'h0);
         check_val("dbg_inst", dbg_inst, 32'h0);
         if (c == 1)
            drive_reset_noise();
         if (c == 4)
            drive_idle();
      end
      arst_n = 1'b1;

      prev_stall = '0;
      prev_inst  = '0;
      exp_inst   = '0;
      for (int j = 0; j < n_cases + 2; j++)
      begin
         @(posedge clk);
         // expected id_ex content of the debug word after this edge
         if (prev_stall[stall_id] && !prev_stall[stall_ex])
            exp_inst = '0;
         else if (!prev_stall[stall_id])
            exp_inst = prev_inst;
         #1;
         check_val("dbg_inst", dbg_inst, exp_inst);
         if (j >= 2)
            check_wb(cs_exp_wd[j-2], cs_exp_wreg[j-2], cs_exp_wdata[j-2]);
         else
            check_wb(32'h0, 32'h0, 32'h0);
         if (j < n_cases)
         begin
            drive_case(j);
            prev_stall = cs_stall[j][stall_w-1:0];
            prev_inst  = cs_inst[j];
         end
         else
         begin
            drive_idle();
            prev_stall = '0;
            prev_inst  = '0;
         end
      end

      $display("Test passed");
      $finish;
   end

endmodule

// ==== list.f ====
ex_pkg.sv
id_ex.sv
alu_logic.sv
alu_arith.sv
ex_result_sel.sv
ex_top.sv
tb_ex_top.sv

// ==== ex_cases.txt ====
# stall aluop alusel reg1 reg2 wd wreg link exp_wd exp_wreg exp_wdata (all hex)
# expected fields are the wb_* values after the second rising edge following the line
00 24 1 f0f0f0f0 ff00ff00 01 1 00000000 01 1 f000f000
00 25 1 0f0f0f0f 00ff00ff 02 1 00000000 02 1 0fff0fff
00 26 1 aaaaaaaa 5555ffff 03 1 00000000 03 1 ffff5555
00 27 1 12345678 0000ffff 04 1 00000000 04 1 edcb0000
00 5c 1 00000000 0000abcd 05 1 00000000 05 1 abcd0000
00 7c 2 00000004 8000000f 06 1 00000000 06 1 000000f0
00 02 2 00000008 f0000000 07 1 00000000 07 1 00f00000
00 03 2 00000024 80000000 08 1 00000000 08 1 f8000000
00 20 4 7fffffff 00000001 09 1 00000000 09 0 80000000
00 21 4 7fffffff 00000001 0a 1 00000000 0a 1 80000000
00 22 4 00000005 00000007 0b 1 00000000 0b 1 fffffffe
00 23 4 00000000 00000001 0c 1 00000000 0c 1 ffffffff
00 2a 4 ffffffff 00000001 0d 1 00000000 0d 1 00000001
00 2b 4 ffffffff 00000001 0e 1 00000000 0e 1 00000000
00 50 6 00000000 00000000 1f 1 00400010 1f 1 00400010
00 25 0 ffffffff 0000ffff 10 1 00000000 10 1 00000000
07 20 4 00000010 00000020 11 1 00000000 00 0 00000000
00 20 4 00000010 00000020 11 1 00000000 11 1 00000030
00 24 1 ffffffff 13579bdf 12 1 00000000 11 1 00000030
1f 25 1 00000100 00000023 13 1 00000000 00 0 00000000
0f 25 1 00000100 00000023 13 1 00000000 12 1 13579bdf
00 25 1 00000100 00000023 13 1 00000000 13 1 00000123
00 22 4 80000000 00000001 14 1 00000000 14 0 7fffffff
